// File: hdl/cu_cmd_pkg.sv
package cu_cmd_pkg;

    // host control word
    localparam int ctrl_w = 32;

    typedef enum logic [7:0] {
        op_compute      = 8'd87,
        op_write_weight = 8'd12
    } opcode_t;

    // word 0, opcode and output channels
    localparam int opcode_lsb = 0;
    localparam int opcode_w = 8;
    localparam int out_chan_lsb = 20;
    localparam int chan_w = 12;

    // word 1, operation, ofmap width, stride
    localparam int oper_lsb = 0;
    localparam int oper_w = 2;
    localparam logic [oper_w-1:0] oper_conv = 2'd0;
    localparam int width_lsb = 2;
    localparam int dim_w = 9;
    localparam int stride_lsb = 11;
    localparam int stride_w = 3;

    // word 2, one-hot kernel size
    localparam int ksize_lsb = 0;
    localparam int ksize_w = 5;

    // status word back to the host
    localparam logic [ctrl_w-1:0] status_clear = '0;
    localparam logic [ctrl_w-1:0] status_weight_done = 1;
    localparam logic [ctrl_w-1:0] status_output_done = '1;

endpackage

// File: hdl/cu_fsm_pkg.sv
package cu_fsm_pkg;

    typedef enum logic [3:0] {
        if_idle,
        if_wait_row,
        if_load_row,
        if_compute,
        if_wait_step,
        if_load_step
    } ifmap_state_t;

    typedef enum logic [3:0] {
        wt_idle,
        wt_reset_addr,
        wt_fetch,
        wt_pair,
        wt_load
    } weight_state_t;

    typedef enum logic [1:0] {
        ww_idle,
        ww_start,
        ww_wait,
        ww_finish
    } ww_state_t;

    // one-hot kernel codes, sizes 1 to 5
    localparam logic [cu_cmd_pkg::ksize_w-1:0] k1 = 5'b00001;
    localparam logic [cu_cmd_pkg::ksize_w-1:0] k2 = 5'b00010;
    localparam logic [cu_cmd_pkg::ksize_w-1:0] k3 = 5'b00100;
    localparam logic [cu_cmd_pkg::ksize_w-1:0] k4 = 5'b01000;
    localparam logic [cu_cmd_pkg::ksize_w-1:0] k5 = 5'b10000;

    // kernel height as a row count
    function automatic logic [2:0] kernel_count(input logic [cu_cmd_pkg::ksize_w-1:0] code);
        case (code)
            k2:      return 3'd2;
            k3:      return 3'd3;
            k4:      return 3'd4;
            k5:      return 3'd5;
            default: return 3'd1;
        endcase
    endfunction

endpackage

// File: hdl/cmd_status.sv
`timescale 1ns/1ns

module cmd_status (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [cu_cmd_pkg::ctrl_w-1:0]     ctrl_0,
    input  logic [cu_cmd_pkg::ctrl_w-1:0]     ctrl_1,
    input  logic [cu_cmd_pkg::ctrl_w-1:0]     ctrl_2,
    input  logic                              write_weight_finish,
    input  logic                              output_finish,
    input  logic                              layer_finish,
    output logic                              compute_active,
    output logic [cu_cmd_pkg::ksize_w-1:0]    kernel_size,
    output logic [cu_cmd_pkg::dim_w-1:0]      ofmap_width,
    output logic [cu_cmd_pkg::stride_w-1:0]   stride,
    output logic [cu_cmd_pkg::chan_w-1:0]     output_channel_size,
    output logic                              ww_transfer_start,
    output logic                              bram_write_en,
    output logic                              axis_en,
    output logic                              axis_clear,
    output logic [cu_cmd_pkg::ctrl_w-1:0]     ctrl_3
);

    cu_cmd_pkg::opcode_t opcode;
    logic [cu_cmd_pkg::oper_w-1:0] operation;
    logic inst_compute;
    logic inst_write_weight;
    logic inst_compute_q;
    logic inst_write_weight_q;
    logic compute_edge;
    logic inst_edge;
    logic axis_en_q;
    logic axis_clear_q;
    cu_fsm_pkg::ww_state_t ww_state;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    assign opcode = cu_cmd_pkg::opcode_t'(ctrl_0[cu_cmd_pkg::opcode_lsb +: cu_cmd_pkg::opcode_w]);
    assign output_channel_size = ctrl_0[cu_cmd_pkg::out_chan_lsb +: cu_cmd_pkg::chan_w];
    assign operation = ctrl_1[cu_cmd_pkg::oper_lsb +: cu_cmd_pkg::oper_w];
    assign ofmap_width = ctrl_1[cu_cmd_pkg::width_lsb +: cu_cmd_pkg::dim_w];
    assign stride = ctrl_1[cu_cmd_pkg::stride_lsb +: cu_cmd_pkg::stride_w];
    assign kernel_size = ctrl_2[cu_cmd_pkg::ksize_lsb +: cu_cmd_pkg::ksize_w];

    assign inst_compute = (opcode == cu_cmd_pkg::op_compute);
    assign inst_write_weight = (opcode == cu_cmd_pkg::op_write_weight);
    assign compute_active = inst_compute && (operation == cu_cmd_pkg::oper_conv);

    // rising edges of either instruction
    assign compute_edge = inst_compute && !inst_compute_q;
    assign inst_edge = compute_edge || (inst_write_weight && !inst_write_weight_q);

    // stream enable held from the edge until the job ends
    assign axis_en = axis_en_q || inst_edge;
    assign axis_clear = axis_clear_q || compute_edge;

    assign ww_transfer_start = (ww_state == cu_fsm_pkg::ww_start);
    assign bram_write_en = (ww_state != cu_fsm_pkg::ww_idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_compute_q <= 1'b0;
            inst_write_weight_q <= 1'b0;
            axis_en_q <= 1'b0;
            axis_clear_q <= 1'b0;
            ctrl_3 <= cu_cmd_pkg::status_clear;
        end else begin
            inst_compute_q <= inst_compute;
            inst_write_weight_q <= inst_write_weight;
            axis_clear_q <= write_weight_finish;
            if (layer_finish || write_weight_finish) begin
                axis_en_q <= 1'b0;
            end else if (inst_edge) begin
                axis_en_q <= 1'b1;
            end
            if (write_weight_finish) begin
                ctrl_3 <= cu_cmd_pkg::status_weight_done;
            end else if (output_finish) begin
                ctrl_3 <= cu_cmd_pkg::status_output_done;
            end else if (inst_edge) begin
                ctrl_3 <= cu_cmd_pkg::status_clear;
            end
        end
    end

    ////////////////////////////////////////
    // weight-write sequence
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ww_state <= cu_fsm_pkg::ww_idle;
        end else if (!inst_write_weight) begin
            ww_state <= cu_fsm_pkg::ww_idle;
        end else begin
            case (ww_state)
                cu_fsm_pkg::ww_idle:  ww_state <= cu_fsm_pkg::ww_start;
                cu_fsm_pkg::ww_start: ww_state <= cu_fsm_pkg::ww_wait;
                cu_fsm_pkg::ww_wait: begin
                    if (write_weight_finish) begin
                        ww_state <= cu_fsm_pkg::ww_finish;
                    end
                end
                // finish holds until the opcode drops
                default: ww_state <= cu_fsm_pkg::ww_finish;
            endcase
        end
    end

endmodule

// File: hdl/ifmap_sequencer.sv
`timescale 1ns/1ns

module ifmap_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              compute_active,
    input  logic [cu_cmd_pkg::ksize_w-1:0]    kernel_size,
    input  logic [cu_cmd_pkg::stride_w-1:0]   stride,
    input  logic [cu_cmd_pkg::dim_w-1:0]      ofmap_width,
    input  logic                              ifmaps_fifo_empty,
    input  logic                              window_done,
    output logic                              load_ifmaps,
    output logic                              window_ready,
    output logic                              all_done
);

    cu_fsm_pkg::ifmap_state_t state;
    cu_fsm_pkg::ifmap_state_t state_next;
    logic [2:0] kernel_rows;
    logic [2:0] load_cnt;
    logic [cu_cmd_pkg::dim_w-1:0] last_idx;
    logic [cu_cmd_pkg::dim_w-1:0] col_cnt;
    logic [cu_cmd_pkg::dim_w-1:0] row_cnt;
    logic last_col;
    logic layer_done;

    assign kernel_rows = cu_fsm_pkg::kernel_count(kernel_size);
    assign last_idx = ofmap_width - 1'b1;
    assign last_col = (col_cnt == last_idx);

    assign window_ready = (state == cu_fsm_pkg::if_compute);
    assign load_ifmaps = (state == cu_fsm_pkg::if_load_row) ||
                         (state == cu_fsm_pkg::if_load_step);
    assign all_done = window_ready && window_done && last_col && (row_cnt == last_idx);

    ////////////////////////////////////////
    // row loads, step loads, compute
    ////////////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            cu_fsm_pkg::if_idle: begin
                // no restart until the host drops the instruction
                if (!layer_done) state_next = cu_fsm_pkg::if_wait_row;
            end
            cu_fsm_pkg::if_wait_row: begin
                if (!ifmaps_fifo_empty) state_next = cu_fsm_pkg::if_load_row;
            end
            cu_fsm_pkg::if_load_row: begin
                if (load_cnt + 3'd1 == kernel_rows) state_next = cu_fsm_pkg::if_compute;
                else state_next = cu_fsm_pkg::if_wait_row;
            end
            cu_fsm_pkg::if_compute: begin
                if (window_done) begin
                    if (all_done) state_next = cu_fsm_pkg::if_idle;
                    else if (last_col) state_next = cu_fsm_pkg::if_wait_row;
                    else state_next = cu_fsm_pkg::if_wait_step;
                end
            end
            cu_fsm_pkg::if_wait_step: begin
                if (!ifmaps_fifo_empty) state_next = cu_fsm_pkg::if_load_step;
            end
            cu_fsm_pkg::if_load_step: begin
                if (load_cnt + 3'd1 == stride) state_next = cu_fsm_pkg::if_compute;
                else state_next = cu_fsm_pkg::if_wait_step;
            end
            default: state_next = cu_fsm_pkg::if_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cu_fsm_pkg::if_idle;
            load_cnt <= 3'd0;
            col_cnt <= '0;
            row_cnt <= '0;
            layer_done <= 1'b0;
        end else begin
            state <= compute_active ? state_next : cu_fsm_pkg::if_idle;
            if (!compute_active) layer_done <= 1'b0;
            else if (all_done) layer_done <= 1'b1;
            // load count restarts on every compute
            if (window_ready || state == cu_fsm_pkg::if_idle) load_cnt <= 3'd0;
            else if (load_ifmaps) load_cnt <= load_cnt + 3'd1;
            // ofmap position, column wraps into the next row
            if (state == cu_fsm_pkg::if_idle) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (window_ready && window_done) begin
                if (last_col) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/weight_sequencer.sv
`timescale 1ns/1ns

module weight_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              compute_active,
    input  logic                              window_ready,
    input  logic [cu_cmd_pkg::ksize_w-1:0]    kernel_size,
    input  logic [cu_cmd_pkg::chan_w-1:0]     output_channel_size,
    input  logic                              weight_from_bram_valid,
    output logic                              load_weight_preload,
    output logic                              load_weight,
    output logic                              bram_port_sel,
    output logic                              bram_control_add1,
    output logic                              bram_control_add2,
    output logic                              wl_transfer_start,
    output logic                              window_done
);

    cu_fsm_pkg::weight_state_t state;
    logic [2:0] kernel_rows;
    logic [2:0] step_cnt;
    logic [cu_cmd_pkg::chan_w-1:0] filter_cnt;
    logic fetch;
    logic pair;
    logic valid_fetch;
    logic last_step;
    logic last_filter;

    assign kernel_rows = cu_fsm_pkg::kernel_count(kernel_size);
    assign fetch = (state == cu_fsm_pkg::wt_fetch);
    assign pair = (state == cu_fsm_pkg::wt_pair);
    assign valid_fetch = fetch && weight_from_bram_valid;
    assign last_step = (step_cnt == kernel_rows - 3'd1);
    assign last_filter = (filter_cnt + 1'b1 == output_channel_size);

    assign load_weight = (state == cu_fsm_pkg::wt_load);
    assign window_done = load_weight && last_filter;
    assign wl_transfer_start = (state == cu_fsm_pkg::wt_reset_addr);
    // fetch rows wait for the BRAM, the second port row is already there
    assign load_weight_preload = valid_fetch || pair;
    assign bram_port_sel = pair;

    ////////////////////////////////////////
    // BRAM address step per kernel size
    ////////////////////////////////////////
    assign bram_control_add1 = weight_from_bram_valid && (
        (load_weight && (kernel_size == cu_fsm_pkg::k1 || kernel_size == cu_fsm_pkg::k5)) ||
        (fetch && step_cnt == 3'd2 && kernel_size == cu_fsm_pkg::k3) ||
        (fetch && step_cnt == 3'd4 && kernel_size == cu_fsm_pkg::k5));

    assign bram_control_add2 = weight_from_bram_valid && (
        (load_weight && (kernel_size == cu_fsm_pkg::k2 || kernel_size == cu_fsm_pkg::k4)) ||
        (pair && step_cnt == 3'd1 && kernel_size == cu_fsm_pkg::k3) ||
        (fetch && step_cnt == 3'd0 &&
            (kernel_size == cu_fsm_pkg::k4 || kernel_size == cu_fsm_pkg::k5)) ||
        (fetch && step_cnt == 3'd2 && kernel_size == cu_fsm_pkg::k5));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cu_fsm_pkg::wt_idle;
        end else if (!compute_active) begin
            state <= cu_fsm_pkg::wt_idle;
        end else begin
            case (state)
                cu_fsm_pkg::wt_idle: begin
                    if (window_ready) state <= cu_fsm_pkg::wt_reset_addr;
                end
                cu_fsm_pkg::wt_reset_addr: state <= cu_fsm_pkg::wt_fetch;
                cu_fsm_pkg::wt_fetch: begin
                    if (weight_from_bram_valid) begin
                        state <= last_step ? cu_fsm_pkg::wt_load : cu_fsm_pkg::wt_pair;
                    end
                end
                cu_fsm_pkg::wt_pair: begin
                    state <= last_step ? cu_fsm_pkg::wt_load : cu_fsm_pkg::wt_fetch;
                end
                cu_fsm_pkg::wt_load: begin
                    state <= last_filter ? cu_fsm_pkg::wt_idle : cu_fsm_pkg::wt_fetch;
                end
                default: state <= cu_fsm_pkg::wt_idle;
            endcase
        end
    end

    // preload step and filter counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= 3'd0;
            filter_cnt <= '0;
        end else begin
            if (wl_transfer_start || load_weight) step_cnt <= 3'd0;
            else if (load_weight_preload) step_cnt <= step_cnt + 3'd1;
            if (state == cu_fsm_pkg::wt_idle) filter_cnt <= '0;
            else if (load_weight) filter_cnt <= filter_cnt + 1'b1;
        end
    end

endmodule

// File: hdl/control_unit.sv
`timescale 1ns/1ns

module control_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [cu_cmd_pkg::ctrl_w-1:0]     ctrl_0,
    input  logic [cu_cmd_pkg::ctrl_w-1:0]     ctrl_1,
    input  logic [cu_cmd_pkg::ctrl_w-1:0]     ctrl_2,
    input  logic                              ifmaps_fifo_empty,
    input  logic                              weight_from_bram_valid,
    input  logic                              write_weight_finish,
    input  logic                              output_finish,
    output logic [cu_cmd_pkg::ctrl_w-1:0]     ctrl_3,
    output logic                              layer_finish,
    output logic                              load_ifmaps,
    output logic                              load_weight_preload,
    output logic                              load_weight,
    output logic [cu_cmd_pkg::ksize_w-1:0]    kernel_size,
    output logic                              bram_port_sel,
    output logic                              bram_control_add1,
    output logic                              bram_control_add2,
    output logic                              bram_transfer_start,
    output logic                              bram_write_en,
    output logic                              axis_en,
    output logic                              axis_clear
);

    logic compute_active;
    logic [cu_cmd_pkg::dim_w-1:0] ofmap_width;
    logic [cu_cmd_pkg::stride_w-1:0] stride;
    logic [cu_cmd_pkg::chan_w-1:0] output_channel_size;
    logic ww_transfer_start;
    logic wl_transfer_start;
    logic window_ready;
    logic window_done;
    logic all_done;

    // weight write and weight read share the BRAM start strobe
    assign bram_transfer_start = ww_transfer_start || wl_transfer_start;

    // last filter of the last window, one cycle wide
    assign layer_finish = all_done && compute_active;

    cmd_status i_cmd_status (
        .clk, .rst_n, .ctrl_0, .ctrl_1, .ctrl_2, .write_weight_finish, .output_finish,
        .layer_finish, .compute_active, .kernel_size, .ofmap_width, .stride,
        .output_channel_size, .ww_transfer_start, .bram_write_en, .axis_en, .axis_clear,
        .ctrl_3
    );

    ifmap_sequencer i_ifmap_sequencer (
        .clk, .rst_n, .compute_active, .kernel_size, .stride, .ofmap_width,
        .ifmaps_fifo_empty, .window_done, .load_ifmaps, .window_ready, .all_done
    );

    weight_sequencer i_weight_sequencer (
        .clk, .rst_n, .compute_active, .window_ready, .kernel_size, .output_channel_size,
        .weight_from_bram_valid, .load_weight_preload, .load_weight, .bram_port_sel,
        .bram_control_add1, .bram_control_add2, .wl_transfer_start, .window_done
    );

endmodule

// File: verif/cu_checker.sv
`timescale 1ns/1ns

module cu_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] ctrl_0,
    input  logic        write_weight_finish,
    input  logic        output_finish,
    input  logic [31:0] ctrl_3,
    input  logic        layer_finish,
    input  logic        load_ifmaps,
    input  logic        load_weight_preload,
    input  logic        load_weight,
    input  logic [4:0]  kernel_size,
    input  logic        bram_port_sel,
    input  logic        bram_control_add1,
    input  logic        bram_control_add2,
    input  logic        bram_transfer_start,
    input  logic        bram_write_en,
    input  logic        axis_en,
    input  logic        axis_clear,
    input  int          exp_k,
    input  int          exp_ifmap,
    input  int          exp_weight,
    input  int          exp_start,
    output int          errors,
    output int          layers
);

    int settle = 0;
    int n_ifmap = 0;
    int n_preload = 0;
    int n_pair = 0;
    int n_weight = 0;
    int n_start = 0;
    int n_finish = 0;
    logic [7:0] op;
    logic [7:0] prev_op = '0;
    logic inst_edge;
    logic edge_q = 1'b0;
    logic lf_q = 1'b0;
    logic wwf_q = 1'b0;
    logic of_q = 1'b0;

    initial begin
        errors = 0;
        layers = 0;
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // outputs sampled on the falling edge while stable
    always @(negedge clk) begin
        op = ctrl_0[7:0];
        inst_edge = (op != prev_op) && (op == 8'(cu_cmd_pkg::op_compute) ||
                                         op == 8'(cu_cmd_pkg::op_write_weight));
        if (!rst_n || settle < 2) begin
            if ({layer_finish, load_ifmaps, load_weight_preload, load_weight, bram_port_sel,
                 bram_control_add1, bram_control_add2, bram_transfer_start, bram_write_en,
                 axis_en, axis_clear} != '0 || kernel_size != '0 || ctrl_3 != '0) begin
                errors++;
                $display("Fail at %0t: outputs not idle around reset", $time);
            end
            if (rst_n) settle++;
        end else begin
            // a new instruction starts a fresh count
            if (inst_edge) begin
                n_ifmap = 0;
                n_preload = 0;
                n_pair = 0;
                n_weight = 0;
                n_start = 0;
                n_finish = 0;
            end
            if (load_ifmaps) n_ifmap++;
            if (load_weight_preload) n_preload++;
            if (bram_port_sel) n_pair++;
            if (bram_transfer_start) n_start++;
            // second port only in a preload, one address step at a time
            compare("bram_port_sel outside a preload",
                    32'(bram_port_sel && !load_weight_preload), 0);
            compare("both bram address steps", 32'(bram_control_add1 && bram_control_add2), 0);
            compare("bram address step outside a weight read",
                    32'((bram_control_add1 || bram_control_add2) &&
                        !(load_weight_preload || load_weight)), 0);
            if (load_weight) begin
                compare("preloads before load_weight", n_preload, exp_k);
                // fetch and pair alternate, starting with a fetch
                compare("second-port preloads before load_weight", n_pair, exp_k / 2);
                n_preload = 0;
                n_pair = 0;
                n_weight++;
            end
            if (inst_edge) compare("axis_en at new instruction", 32'(axis_en), 1);
            // clear pulses on a compute edge and one cycle after a weight write
            compare("axis_clear", 32'(axis_clear),
                    32'((inst_edge && op == 8'(cu_cmd_pkg::op_compute)) || wwf_q));
            ////////////////////////////////////////
            // end of layer and status events
            ////////////////////////////////////////
            if (layer_finish) begin
                n_finish++;
                compare("layer_finish pulses", n_finish, 1);
                compare("ifmap loads", n_ifmap, exp_ifmap);
                compare("weight loads", n_weight, exp_weight);
                compare("bram starts per layer", n_start, exp_start);
                compare("kernel_size", 32'(kernel_size), 32'(1) << (exp_k - 1));
                layers++;
            end
            if (write_weight_finish) begin
                compare("bram starts per write", n_start, 1);
                compare("bram_write_en at write finish", 32'(bram_write_en), 1);
            end
            if (lf_q) compare("axis_en after layer_finish", 32'(axis_en), 0);
            if (wwf_q) compare("ctrl_3 after write", ctrl_3, cu_cmd_pkg::status_weight_done);
            if (of_q) compare("ctrl_3 after output", ctrl_3, cu_cmd_pkg::status_output_done);
            if (edge_q) compare("ctrl_3 after new instruction", ctrl_3, cu_cmd_pkg::status_clear);
            // write enable follows a settled opcode
            if (op == prev_op) begin
                compare("bram_write_en", 32'(bram_write_en),
                        32'(op == 8'(cu_cmd_pkg::op_write_weight)));
            end
        end
        edge_q = inst_edge;
        lf_q = layer_finish;
        wwf_q = write_weight_finish;
        of_q = output_finish;
        prev_op = op;
    end

endmodule

// File: verif/tb_control_unit.sv
`timescale 1ns/1ns

module tb_control_unit;

    localparam int num_layers = 8;
    // worst layer is K=5, W=4, S=2, C=3: 16 windows of 1+3*6 cycles and 44 row loads,
    // doubled for stalls, plus host overhead per layer
    localparam int layer_cycles = 2 * (16 * 19 + 44 * 2) + 40;
    localparam int cycle_limit = num_layers * layer_cycles * 2;

    logic clk;
    logic rst_n;
    logic [31:0] ctrl_0;
    logic [31:0] ctrl_1;
    logic [31:0] ctrl_2;
    logic ifmaps_fifo_empty;
    logic weight_from_bram_valid;
    logic write_weight_finish;
    logic output_finish;
    logic [31:0] ctrl_3;
    logic layer_finish;
    logic load_ifmaps;
    logic load_weight_preload;
    logic load_weight;
    logic [4:0] kernel_size;
    logic bram_port_sel;
    logic bram_control_add1;
    logic bram_control_add2;
    logic bram_transfer_start;
    logic bram_write_en;
    logic axis_en;
    logic axis_clear;

    int exp_k;
    int exp_ifmap;
    int exp_weight;
    int exp_start;
    int errors;
    int layers;
    int cycles;
    logic [15:0] lfsr = 16'd12053;

    control_unit i_control_unit (.*);

    cu_checker i_cu_checker (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // expected pulse counts of one layer
    ////////////////////////////////////////
    function automatic void layer_counts(input int k, input int w, input int s, input int c,
                                         output int n_ifmap, output int n_weight,
                                         output int n_start);
        // K rows at each row start, S rows for every later column
        n_ifmap = w * (k + (w - 1) * s);
        // one load per filter per window
        n_weight = c * w * w;
        n_start = w * w;
    endfunction

    task automatic write_weights();
        @(posedge clk);
        #2;
        ctrl_0 = 32'(cu_cmd_pkg::op_write_weight);
        repeat (4) @(posedge clk);
        #2;
        write_weight_finish = 1'b1;
        @(posedge clk);
        #2;
        write_weight_finish = 1'b0;
        // write enable must stay up until the opcode goes away
        repeat (3) @(posedge clk);
        #2;
        ctrl_0 = '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic run_layer(input int k, input int w, input int s, input int c);
        @(posedge clk);
        #2;
        layer_counts(k, w, s, c, exp_ifmap, exp_weight, exp_start);
        exp_k = k;
        ctrl_1 = {18'd0, 3'(s), 9'(w), 2'd0};
        ctrl_2 = 32'(1) << (k - 1);
        ctrl_0 = {12'(c), 12'd1, 8'(cu_cmd_pkg::op_compute)};
        @(negedge clk);
        while (!layer_finish) @(negedge clk);
        @(posedge clk);
        #2;
        output_finish = 1'b1;
        @(posedge clk);
        #2;
        output_finish = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        ctrl_0 = '0;
        repeat (2) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fifo empty and BRAM valid stalls, about one cycle in four
    initial begin
        ifmaps_fifo_empty = 1'b0;
        weight_from_bram_valid = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            ifmaps_fifo_empty = (rand_bits(2) == 3);
            weight_from_bram_valid = (rand_bits(2) != 3);
        end
    end

    initial begin
        int k;
        int w;
        int s;
        int c;
        rst_n = 1'b0;
        ctrl_0 = '0;
        ctrl_1 = '0;
        ctrl_2 = '0;
        write_weight_finish = 1'b0;
        output_finish = 1'b0;
        exp_k = 0;
        exp_ifmap = 0;
        exp_weight = 0;
        exp_start = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) @(posedge clk);
        for (int n = 0; n < num_layers; n++) begin
            write_weights();
            @(negedge clk);
            k = rand_bits(3) % 5 + 1;
            w = rand_bits(2) % 3 + 2;
            s = rand_bits(1) + 1;
            c = rand_bits(2) % 3 + 1;
            run_layer(k, w, s, c);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d, layers: %0d", errors, layers);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("errors: %0d, layers: %0d", errors, layers);
        $display("tests failed");
        $finish;
    end

endmodule

// File: project.f
hdl/cu_cmd_pkg.sv
hdl/cu_fsm_pkg.sv
hdl/cmd_status.sv
hdl/ifmap_sequencer.sv
hdl/weight_sequencer.sv
hdl/control_unit.sv
verif/cu_checker.sv
verif/tb_control_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_control_unit -f project.f
out=$(./obj_dir/Vtb_control_unit)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
